/* barrel_core.f */
source/barrel_pkg.sv
source/pipe_if.sv
source/host_regs.sv
source/decode_stage.sv
source/execute_stage.sv
source/result_stage.sv
source/barrel_core.sv
verification/barrel_core_assert.sv
verification/barrel_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= barrel_core.f
TB_TOP    ?= barrel_core_tb
RTL_TOP   ?= barrel_core
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)
	-./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "Simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/barrel_core_tb.sv */
module barrel_core_tb;
   import barrel_pkg::*;

   typedef enum {WRITE, READ_CHECK, ERR_CHECK, WAIT_HALT} kind_t;

   typedef struct {
      kind_t     kind;
      logic      wr;                      // Direction, used by ERR_CHECK
      apb_addr_t addr;
      word_t     data;
      word_t     exp;
   } entry_t;

   logic        clk;
   logic        reset;
   logic        psel;
   logic        penable;
   logic        pwrite;
   apb_addr_t   paddr;
   word_t       pwdata;
   word_t       prdata;
   logic        pready;
   logic        pslverr;

   entry_t      table_q[$];               // Stimulus and expected values
   word_t       exp_rf [4][8];            // Expected registers per thread
   word_t       wa;
   word_t       wb;
   int unsigned cycles;
   int unsigned limit;
   int          errors;

   barrel_core #(.DMEM_AW(8)) DUT (
      .clk     (clk),
      .reset   (reset),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   ////////////////////////////////////////
   // Failure reporting and compares
   task automatic report_failure();
      errors++;
      $display("CHECKS FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
         report_failure();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
         report_failure();
      end
   endtask

   // Watchdog over the whole run
   always @(posedge clk) begin
      cycles++;
      if (limit != 0 && cycles > limit) begin
         $display("Timeout: table not finished after %0d cycles", cycles);
         report_failure();
      end
   end

   ////////////////////////////////////////
   // APB master, drives on falling edges
   task automatic apb_xfer(input logic wr, input apb_addr_t addr, input word_t wdata,
                           output word_t rdata, output logic err);
      int waits;
      waits = 0;
      @(negedge clk);
      psel    = 1'b1;                     // Setup phase
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      while (!pready) begin               // Wait state for memory reads
         waits++;
         if (waits > 8) begin
            $display("APB slave never raised pready at address %h", addr);
            report_failure();
         end
         @(negedge clk);
      end
      rdata = prdata;
      err   = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   ////////////////////////////////////////
   // Table building
   function automatic instr_t encode(op_t op, cond_t cond, int r1, int r2, int r3,
                                     int off, bit stall);
      instr_t i;
      i = '0;
      i[OP_LSB +: 4]            = op;
      i[COND_LSB +: 4]          = cond;
      i[R1_LSB +: 3]            = 3'(r1);
      i[R2_LSB +: 3]            = 3'(r2);
      i[R3_LSB +: 3]            = 3'(r3);
      i[OFFSET_LSB +: OFFSET_W] = 9'(off);   // Two's complement offset
      i[STALL_BIT]              = stall;
      return i;
   endfunction

   task automatic add_entry(kind_t kind, logic wr, apb_addr_t addr, word_t data, word_t exp);
      entry_t e;
      e = '{kind, wr, addr, data, exp};
      table_q.push_back(e);
   endtask

   task automatic put_instr(int t, int pc, instr_t i);
      add_entry(WRITE, 1'b1, 16'(IMEM_BASE + 4 * (t * 512 + pc)), i, '0);
   endtask

   task automatic add_reg_reads(int t);
      for (int r = 0; r < 8; r++)
         add_entry(READ_CHECK, 1'b0, 16'(REG_BASE + t * 32 + r * 4), '0, exp_rf[t][r]);
   endtask

   task automatic build_table();
      // Reset state, everything reads 0
      add_entry(READ_CHECK, 1'b0, STATUS_ADDR, '0, 32'd0);
      for (int t = 0; t < 4; t++)
         for (int r = 0; r < 8; r++)
            add_entry(READ_CHECK, 1'b0, 16'(REG_BASE + t * 32 + r * 4), '0, 32'd0);
      add_entry(WRITE, 1'b1, DMEM_BASE + 16'd16, wa, '0);   // Words 4 and 5
      add_entry(WRITE, 1'b1, DMEM_BASE + 16'd20, wb, '0);
      add_entry(READ_CHECK, 1'b0, DMEM_BASE + 16'd16, '0, wa);

      // Thread 0, ALU mix then stall, delay loop, final stall
      put_instr(0, 0, encode(OP_ADDI, COND_AL, 0, 0, 1, 100, 0));
      put_instr(0, 1, encode(OP_ADDI, COND_AL, 0, 0, 2, -7, 0));
      put_instr(0, 2, encode(OP_ADD, COND_AL, 1, 2, 3, 0, 0));
      put_instr(0, 3, encode(OP_SUB, COND_AL, 1, 2, 4, 0, 0));
      put_instr(0, 4, encode(OP_AND, COND_AL, 1, 2, 5, 0, 0));
      put_instr(0, 5, encode(OP_OR, COND_AL, 1, 2, 6, 0, 0));
      put_instr(0, 6, encode(OP_XOR, COND_AL, 1, 2, 7, 0, 0));
      put_instr(0, 7, encode(OP_NOP, COND_AL, 0, 0, 0, 0, 1));     // First halt
      put_instr(0, 8, encode(OP_ADDI, COND_AL, 0, 0, 1, 0, 0));
      put_instr(0, 9, encode(OP_ADDI, COND_AL, 0, 0, 2, 12, 0));
      put_instr(0, 10, encode(OP_ADDI, COND_AL, 1, 0, 1, 1, 0));
      put_instr(0, 11, encode(OP_CMP, COND_AL, 1, 2, 0, 0, 0));
      put_instr(0, 12, encode(OP_BRANCH, COND_NE, 0, 0, 0, -3, 0)); // Back to 10
      put_instr(0, 13, encode(OP_NOP, COND_AL, 0, 0, 0, 0, 1));
      put_instr(0, 14, encode(OP_JUMP, COND_AL, 0, 0, 0, 14, 0));
      // Thread 1, predication on flags
      put_instr(1, 0, encode(OP_ADDI, COND_AL, 0, 0, 1, 5, 0));
      put_instr(1, 1, encode(OP_ADDI, COND_AL, 0, 0, 2, 5, 0));
      put_instr(1, 2, encode(OP_CMP, COND_AL, 1, 2, 0, 0, 0));      // Equal
      put_instr(1, 3, encode(OP_ADDI, COND_EQ, 0, 0, 3, 11, 0));
      put_instr(1, 4, encode(OP_ADDI, COND_NE, 0, 0, 4, 22, 0));
      put_instr(1, 5, encode(OP_ADDI, COND_AL, 0, 0, 5, 3, 0));
      put_instr(1, 6, encode(OP_SUB, COND_AL, 5, 1, 6, 0, 0));      // 3 - 5 borrows
      put_instr(1, 7, encode(OP_ADDI, COND_CC, 0, 0, 7, 33, 0));
      put_instr(1, 8, encode(OP_ADDI, COND_CS, 0, 0, 3, 44, 0));
      put_instr(1, 9, encode(OP_ADDI, COND_LT, 0, 0, 2, 55, 0));
      put_instr(1, 10, encode(OP_ADDI, COND_GE, 0, 0, 1, 66, 0));
      put_instr(1, 11, encode(OP_JUMP, COND_AL, 0, 0, 0, 11, 0));
      // Thread 2, count loop and a jump over an ADDI
      put_instr(2, 0, encode(OP_ADDI, COND_AL, 0, 0, 2, 5, 0));
      put_instr(2, 1, encode(OP_ADDI, COND_AL, 1, 0, 1, 1, 0));
      put_instr(2, 2, encode(OP_CMP, COND_AL, 1, 2, 0, 0, 0));
      put_instr(2, 3, encode(OP_BRANCH, COND_NE, 0, 0, 0, -3, 0));
      put_instr(2, 4, encode(OP_JUMP, COND_AL, 0, 0, 0, 6, 0));
      put_instr(2, 5, encode(OP_ADDI, COND_AL, 0, 0, 3, 77, 0));    // Skipped
      put_instr(2, 6, encode(OP_ADDI, COND_AL, 1, 0, 4, 10, 0));
      put_instr(2, 7, encode(OP_JUMP, COND_AL, 0, 0, 0, 7, 0));
      // Thread 3, load, add, store, reload
      put_instr(3, 0, encode(OP_LOAD, COND_AL, 0, 0, 1, 4, 0));
      put_instr(3, 1, encode(OP_LOAD, COND_AL, 0, 0, 2, 5, 0));
      put_instr(3, 2, encode(OP_ADD, COND_AL, 1, 2, 3, 0, 0));
      put_instr(3, 3, encode(OP_STORE, COND_AL, 0, 3, 0, 6, 0));
      put_instr(3, 4, encode(OP_LOAD, COND_AL, 0, 0, 4, 6, 0));
      put_instr(3, 5, encode(OP_JUMP, COND_AL, 0, 0, 0, 5, 0));

      // Run to the first stall
      add_entry(WRITE, 1'b1, CMD_ADDR, 32'd1, '0);
      add_entry(WAIT_HALT, 1'b0, STATUS_ADDR, '0, '0);
      add_entry(READ_CHECK, 1'b0, STATUS_ADDR, '0, 32'd3);
      add_entry(ERR_CHECK, 1'b1, IMEM_BASE, 32'hdead_beef, '0);    // Run is 1
      add_entry(ERR_CHECK, 1'b0, REG_BASE + 16'd4, '0, '0);
      add_entry(ERR_CHECK, 1'b0, 16'h0008, '0, '0);                // Unmapped
      add_entry(WRITE, 1'b1, CMD_ADDR, 32'd0, '0);
      add_entry(READ_CHECK, 1'b0, STATUS_ADDR, '0, 32'd1);
      exp_rf[0] = '{32'd0, 32'd100, 32'hffff_fff9, 32'd100 + 32'hffff_fff9,
                    32'd100 - 32'hffff_fff9, 32'd100 & 32'hffff_fff9,
                    32'd100 | 32'hffff_fff9, 32'd100 ^ 32'hffff_fff9};
      add_reg_reads(0);

      // Run alone stays halted, step goes on to the final stall
      add_entry(WRITE, 1'b1, CMD_ADDR, 32'd1, '0);
      add_entry(READ_CHECK, 1'b0, CMD_ADDR, '0, 32'd1);            // Run bit reads back
      add_entry(READ_CHECK, 1'b0, STATUS_ADDR, '0, 32'd3);
      add_entry(WRITE, 1'b1, CMD_ADDR, 32'd3, '0);
      add_entry(READ_CHECK, 1'b0, STATUS_ADDR, '0, 32'd2);
      add_entry(WAIT_HALT, 1'b0, STATUS_ADDR, '0, '0);
      add_entry(WRITE, 1'b1, CMD_ADDR, 32'd0, '0);
      add_entry(READ_CHECK, 1'b0, STATUS_ADDR, '0, 32'd1);
      add_entry(ERR_CHECK, 1'b1, 16'h4000, 32'd1, '0);             // Unmapped, run is 0

      exp_rf[0][1] = 32'd12;              // Delay loop counter and limit
      exp_rf[0][2] = 32'd12;
      exp_rf[1] = '{32'd0, 32'd5, 32'd55, 32'd11, 32'd0, 32'd3, 32'd3 - 32'd5, 32'd33};
      exp_rf[2] = '{32'd0, 32'd5, 32'd5, 32'd0, 32'd15, 32'd0, 32'd0, 32'd0};
      exp_rf[3] = '{32'd0, wa, wb, wa + wb, wa + wb, 32'd0, 32'd0, 32'd0};
      for (int t = 0; t < 4; t++)
         add_reg_reads(t);
      add_entry(READ_CHECK, 1'b0, DMEM_BASE + 16'd20, '0, wb);
      add_entry(READ_CHECK, 1'b0, DMEM_BASE + 16'd24, '0, wa + wb);  // Stored sum
   endtask

   ////////////////////////////////////////
   // Apply one table entry
   task automatic run_entry(input entry_t e);
      word_t rdata;
      logic  err;
      case (e.kind)
         WRITE: begin
            apb_xfer(1'b1, e.addr, e.data, rdata, err);
            check_bit($sformatf("pslverr@%h", e.addr), err, 1'b0);
         end
         READ_CHECK: begin
            apb_xfer(1'b0, e.addr, '0, rdata, err);
            check_bit($sformatf("pslverr@%h", e.addr), err, 1'b0);
            check_word($sformatf("prdata@%h", e.addr), rdata, e.exp);
         end
         ERR_CHECK: begin
            apb_xfer(e.wr, e.addr, e.data, rdata, err);
            check_bit($sformatf("pslverr@%h", e.addr), err, 1'b1);
         end
         default: begin                   // Poll halted bit
            do
               apb_xfer(1'b0, STATUS_ADDR, '0, rdata, err);
            while (!rdata[0]);
         end
      endcase
   endtask

   initial begin
      reset   = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      errors  = 0;
      cycles  = 0;
      limit   = 0;
      void'($urandom(32'h4cdf_8ee5));
      wa = $urandom;
      wb = $urandom;
      build_table();
      limit = table_q.size() * 64;
      repeat (2) @(posedge clk);
      @(negedge clk) reset = 1'b0;
      foreach (table_q[i])
         run_entry(table_q[i]);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
         $finish;
      end else begin
         report_failure();
      end
   end

endmodule

/* verification/barrel_core_assert.sv */
module barrel_core_assert (
   input logic clk,
   input logic reset,
   input logic psel,
   input logic penable,
   input logic pready,
   input logic pslverr
);

   ////////////////////////////////////////
   // APB slave response rules
   ready_in_access: assert property (@(posedge clk) disable iff (reset)
      pready |-> psel && penable)
      else $error("pready outside an access phase");

   err_with_ready: assert property (@(posedge clk) disable iff (reset)
      pslverr |-> pready)               // Error only on completion
      else $error("pslverr without pready");

   quiet_in_reset: assert property (@(posedge clk) reset |-> !pready)
      else $error("pready high during reset");

endmodule

bind barrel_core barrel_core_assert u_apb_assert (
   .clk     (clk),
   .reset   (reset),
   .psel    (psel),
   .penable (penable),
   .pready  (pready),
   .pslverr (pslverr)
);

/* source/barrel_core.sv */
module barrel_core #(
   parameter int DMEM_AW = 8
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  barrel_pkg::apb_addr_t paddr,
   input  barrel_pkg::word_t     pwdata,
   output barrel_pkg::word_t     prdata,
   output logic                  pready,
   output logic                  pslverr
);

   stage_if                     dx ();     // ID/EX
   wb_if                        wb ();     // EX/MEM and writeback
   host_if #(.DMEM_AW(DMEM_AW)) host ();

   host_regs #(
      .DMEM_AW (DMEM_AW)
   ) u_host_regs (
      .clk     (clk),
      .reset   (reset),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .host    (host)
   );

   decode_stage u_decode (
      .clk   (clk),
      .reset (reset),
      .dx    (dx),
      .wb    (wb),
      .host  (host)
   );

   execute_stage u_execute (
      .clk   (clk),
      .reset (reset),
      .dx    (dx),
      .wb    (wb),
      .host  (host)
   );

   result_stage #(
      .DMEM_AW (DMEM_AW)
   ) u_result (
      .clk   (clk),
      .reset (reset),
      .wb    (wb),
      .host  (host)
   );

endmodule

/* source/result_stage.sv */
module result_stage #(
   parameter int DMEM_AW = 8
) (
   input logic    clk,
   input logic    reset,
   wb_if.result   wb,
   host_if.result host
);
   import barrel_pkg::*;

   word_t              dmem [2**DMEM_AW];
   logic [DMEM_AW-1:0] addr_a;             // Word index from r1 + offset
   word_t              load_data;

   // MEM/WB
   logic               mw_we;
   logic               mw_m2r;
   logic               mw_stall;
   tid_t               mw_tid;
   reg_idx_t           mw_r3;
   word_t              mw_alu;

   assign addr_a = wb.alu_result[DMEM_AW-1:0];

   ////////////////////////////////////////
   // Data memory, A for pipeline, B for host
   always_ff @(posedge clk) begin
      if (host.pipe_en) begin
         if (wb.mem_we)
            dmem[addr_a] <= wb.store_data;
         load_data <= dmem[addr_a];        // Used in WB
      end
      if (host.dmem_we)
         dmem[host.dmem_addr] <= host.dmem_wdata;
      host.dmem_rdata <= dmem[host.dmem_addr];
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         mw_we    <= 1'b0;
         mw_m2r   <= 1'b0;
         mw_stall <= 1'b0;
      end else if (host.pipe_en) begin
         mw_we    <= wb.reg_we;
         mw_m2r   <= wb.mem_to_reg;
         mw_stall <= wb.stall;
      end
   end

   always_ff @(posedge clk) begin
      if (host.pipe_en) begin
         mw_tid <= wb.tid;
         mw_r3  <= wb.r3;
         mw_alu <= wb.alu_result;
      end
   end

   // Writeback select
   assign wb.rf_we   = mw_we;
   assign wb.rf_tid  = mw_tid;
   assign wb.rf_r3   = mw_r3;
   assign wb.rf_data = mw_m2r ? load_data : mw_alu;

   assign host.wb_stall = mw_stall;        // Freezes pipe until step

endmodule

/* source/execute_stage.sv */
module execute_stage (
   input logic      clk,
   input logic      reset,
   stage_if.execute dx,
   wb_if.execute    wb,
   host_if.execute  host
);
   import barrel_pkg::*;

   flags_t      flags [NUM_THREADS];
   logic        fn, fz, fc, fv;            // Flags of the thread in EX
   word_t       a;
   word_t       b;
   word_t       b_eff;
   word_t       result;
   logic [32:0] sum;
   logic        use_imm;
   logic        sub;
   logic        pass;
   logic        go;                        // Valid and passing
   logic        writes_reg;
   logic        sets_flags;

   ////////////////////////////////////////
   // Operands and ALU
   assign use_imm = dx.op inside {OP_ADDI, OP_LOAD, OP_STORE, OP_BRANCH};
   assign a = (dx.op == OP_BRANCH) ? 32'(dx.pc) + 32'd1 : dx.r1_data;
   assign b = use_imm ? {{(32-OFFSET_W){dx.offset[OFFSET_W-1]}}, dx.offset} : dx.r2_data;

   // One adder, subtract as a + ~b + 1
   assign sub   = dx.op inside {OP_SUB, OP_CMP};
   assign b_eff = sub ? ~b : b;
   assign sum   = {1'b0, a} + {1'b0, b_eff} + 33'(sub);

   always_comb begin
      case (dx.op)
         OP_AND:  result = a & b;
         OP_OR:   result = a | b;
         OP_XOR:  result = a ^ b;
         default: result = sum[31:0];      // Add, sub, address, branch target
      endcase
   end

   ////////////////////////////////////////
   // Pass decoder on this thread's flags
   assign {fn, fz, fc, fv} = flags[dx.tid];

   always_comb begin
      case (dx.cond)
         COND_AL: pass = 1'b1;
         COND_EQ: pass = fz;
         COND_NE: pass = !fz;
         COND_CS: pass = fc;               // C set means no borrow
         COND_CC: pass = !fc;
         COND_MI: pass = fn;
         COND_PL: pass = !fn;
         COND_VS: pass = fv;
         COND_VC: pass = !fv;
         COND_LT: pass = fn != fv;
         COND_GE: pass = fn == fv;
         default: pass = 1'b0;             // 11 to 15
      endcase
   end

   assign go         = dx.valid && pass;
   assign writes_reg = dx.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LOAD};
   assign sets_flags = dx.op inside {OP_ADD, OP_SUB, OP_CMP};

   // Redirect own thread only, jump ignores pass
   assign dx.redirect     = dx.valid && ((dx.op == OP_JUMP) || (dx.op == OP_BRANCH && pass));
   assign dx.redirect_tid = dx.tid;
   assign dx.redirect_pc  = (dx.op == OP_JUMP) ? dx.offset : result[$bits(pc_t)-1:0];

   ////////////////////////////////////////
   // Flags and EX/MEM register
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int t = 0; t < NUM_THREADS; t++)
            flags[t] <= '0;
         wb.reg_we     <= 1'b0;
         wb.mem_we     <= 1'b0;
         wb.mem_to_reg <= 1'b0;
         wb.stall      <= 1'b0;
      end else if (host.pipe_en) begin
         if (go && sets_flags)
            flags[dx.tid] <= {sum[31], sum[31:0] == '0, sum[32],
                              (a[31] == b_eff[31]) && (sum[31] != a[31])};
         wb.reg_we     <= go && writes_reg;
         wb.mem_we     <= go && (dx.op == OP_STORE);
         wb.mem_to_reg <= dx.op == OP_LOAD;
         wb.stall      <= dx.valid && dx.stall;   // Stall holds even if not passing
      end
   end

   always_ff @(posedge clk) begin
      if (host.pipe_en) begin
         wb.tid        <= dx.tid;
         wb.r3         <= dx.r3;
         wb.alu_result <= result;
         wb.store_data <= dx.r2_data;
      end
   end

endmodule

/* source/decode_stage.sv */
module decode_stage (
   input logic     clk,
   input logic     reset,
   stage_if.decode dx,
   wb_if.decode    wb,
   host_if.decode  host
);
   import barrel_pkg::*;

   instr_t   imem [2**$bits(imem_addr_t)];
   word_t    rf [NUM_THREADS][NUM_REGS];   // One bank per thread
   pc_t      pc [NUM_THREADS];
   tid_t     tid_cnt;                      // Thread in IF

   // IF/ID
   instr_t   instr;
   logic     if_valid;
   tid_t     if_tid;
   pc_t      if_pc;

   op_t      op;
   op_t      dec_op;
   reg_idx_t r1;
   reg_idx_t r2;
   tid_t     p1_tid;
   reg_idx_t p1_idx;
   word_t    r1_data;
   word_t    r2_data;

   ////////////////////////////////////////
   // Fetch
   always_ff @(posedge clk) begin
      if (host.imem_we)
         imem[host.imem_addr] <= host.imem_data;        // Port B, host load
      if (host.pipe_en) begin
         instr  <= imem[{tid_cnt, pc[tid_cnt]}];         // Port A
         if_tid <= tid_cnt;
         if_pc  <= pc[tid_cnt];
      end
   end

   // Thread rotation and PCs
   always_ff @(posedge clk) begin
      if (reset) begin
         tid_cnt  <= '0;
         if_valid <= 1'b0;
         for (int t = 0; t < NUM_THREADS; t++)
            pc[t] <= '0;
      end else if (host.pipe_en) begin
         tid_cnt     <= tid_cnt + 1'b1;                  // 3 wraps to 0
         if_valid    <= 1'b1;
         pc[tid_cnt] <= pc[tid_cnt] + 1'b1;
         if (dx.redirect)
            pc[dx.redirect_tid] <= dx.redirect_pc;       // Wins over increment
      end
   end

   ////////////////////////////////////////
   // Decode and register read
   assign op     = instr[OP_LSB +: $bits(op_t)];
   assign dec_op = (op <= OP_JUMP) ? op : OP_NOP;        // Unused codes
   assign r1     = instr[R1_LSB +: $bits(reg_idx_t)];
   assign r2     = instr[R2_LSB +: $bits(reg_idx_t)];

   // Host borrows port 1 while frozen
   assign p1_tid  = host.pipe_en ? if_tid : host.reg_rd_tid;
   assign p1_idx  = host.pipe_en ? r1 : host.reg_rd_idx;
   assign r1_data = rf[p1_tid][p1_idx];
   assign r2_data = rf[if_tid][r2];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int t = 0; t < NUM_THREADS; t++)
            for (int r = 0; r < NUM_REGS; r++)
               rf[t][r] <= '0;
      end else if (wb.rf_we && host.pipe_en) begin
         rf[wb.rf_tid][wb.rf_r3] <= wb.rf_data;          // WB of c+4
      end
   end

   always_ff @(posedge clk)
      host.reg_rd_data <= r1_data;                        // Ready in READ_WAIT

   ////////////////////////////////////////
   // ID/EX register
   always_ff @(posedge clk) begin
      if (reset) begin
         dx.valid <= 1'b0;
         dx.op    <= OP_NOP;
         dx.stall <= 1'b0;
      end else if (host.pipe_en) begin
         dx.valid <= if_valid;
         dx.op    <= dec_op;
         dx.stall <= instr[STALL_BIT];
      end
   end

   always_ff @(posedge clk) begin
      if (host.pipe_en) begin
         dx.tid     <= if_tid;
         dx.pc      <= if_pc;
         dx.cond    <= instr[COND_LSB +: $bits(cond_t)];
         dx.r1_data <= r1_data;
         dx.r2_data <= r2_data;
         dx.r3      <= instr[R3_LSB +: $bits(reg_idx_t)];
         dx.offset  <= instr[OFFSET_LSB +: OFFSET_W];
      end
   end

endmodule

/* source/host_regs.sv */
module host_regs #(
   parameter int DMEM_AW = 8
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  barrel_pkg::apb_addr_t paddr,
   input  barrel_pkg::word_t     pwdata,
   output barrel_pkg::word_t     prdata,
   output logic                  pready,
   output logic                  pslverr,
   host_if.host                  host
);
   import barrel_pkg::*;

   localparam int DMEM_TOP = int'(DMEM_BASE) + (4 << DMEM_AW);

   typedef enum logic [1:0] {IDLE, ACCESS, READ_WAIT} apb_state_t;

   apb_state_t state;
   logic       run;
   logic       step;          // One-cycle step pulse
   logic       cmd_hit;
   logic       status_hit;
   logic       reg_hit;
   logic       dmem_hit;
   logic       imem_hit;
   logic       legal;
   logic       mem_read;      // Synchronous memory, needs the wait cycle
   logic       wr_en;

   ////////////////////////////////////////
   // Address decode
   // paddr holds through setup and access
   assign cmd_hit    = (paddr == CMD_ADDR);
   assign status_hit = (paddr == STATUS_ADDR) && !pwrite;                      // Read only
   assign reg_hit    = (paddr[15:7] == REG_BASE[15:7]) && !pwrite && !run;    // Halted reads only
   assign dmem_hit   = (paddr >= DMEM_BASE) && (32'(paddr) < DMEM_TOP);
   assign imem_hit   = (paddr[15:13] == IMEM_BASE[15:13]) && pwrite && !run;  // Halted writes only
   assign legal      = cmd_hit || status_hit || reg_hit || dmem_hit || imem_hit;
   assign mem_read   = !pwrite && (reg_hit || dmem_hit);
   assign wr_en      = (state == ACCESS) && pwrite;

   // Host windows onto the stage memories
   assign host.imem_we    = wr_en && imem_hit;
   assign host.imem_addr  = paddr[12:2];
   assign host.imem_data  = pwdata;
   assign host.reg_rd_tid = paddr[6:5];
   assign host.reg_rd_idx = paddr[4:2];
   assign host.dmem_addr  = paddr[DMEM_AW+1:2];
   assign host.dmem_we    = wr_en && dmem_hit;
   assign host.dmem_wdata = pwdata;

   assign host.pipe_en = (run && !host.wb_stall) || step;   // Step overrides a stall

   ////////////////////////////////////////
   // APB FSM and command register
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= IDLE;
         run   <= 1'b0;
         step  <= 1'b0;
      end else begin
         step <= 1'b0;
         case (state)
            IDLE: begin
               if (psel && !penable)         // Setup phase
                  state <= ACCESS;
            end
            ACCESS: begin
               state <= mem_read ? READ_WAIT : IDLE;
               if (pwrite && cmd_hit) begin
                  run  <= pwdata[CMD_RUN_BIT];
                  step <= pwdata[CMD_STEP_BIT];
               end
            end
            default: state <= IDLE;          // READ_WAIT done
         endcase
      end
   end

   // Completion and read data
   always_comb begin
      pready  = 1'b0;
      pslverr = 1'b0;
      prdata  = '0;
      case (state)
         ACCESS: begin
            pready  = !mem_read;
            pslverr = !legal;                // No side effect either
            if (cmd_hit && !pwrite)
               prdata[CMD_RUN_BIT] = run;
            if (status_hit)
               prdata[1:0] = {run, host.wb_stall};
         end
         READ_WAIT: begin
            pready = 1'b1;
            prdata = reg_hit ? host.reg_rd_data : host.dmem_rdata;
         end
         default: ;
      endcase
   end

endmodule

/* source/pipe_if.sv */
// ID/EX stage plus the redirect path back to fetch
interface stage_if;
   import barrel_pkg::*;

   logic                valid;
   tid_t                tid;
   pc_t                 pc;
   op_t                 op;
   cond_t               cond;
   word_t               r1_data;
   word_t               r2_data;
   reg_idx_t            r3;
   logic [OFFSET_W-1:0] offset;
   logic                stall;
   logic                redirect;       // Taken branch or jump
   tid_t                redirect_tid;
   pc_t                 redirect_pc;

   modport decode  (output valid, tid, pc, op, cond, r1_data, r2_data, r3, offset, stall,
                    input  redirect, redirect_tid, redirect_pc);
   modport execute (input  valid, tid, pc, op, cond, r1_data, r2_data, r3, offset, stall,
                    output redirect, redirect_tid, redirect_pc);
endinterface

// EX/MEM stage forward, register write port back to decode
interface wb_if;
   import barrel_pkg::*;

   tid_t     tid;
   reg_idx_t r3;
   logic     reg_we;
   logic     mem_to_reg;
   word_t    alu_result;
   word_t    store_data;
   logic     mem_we;
   logic     stall;
   logic     rf_we;
   tid_t     rf_tid;
   reg_idx_t rf_r3;
   word_t    rf_data;

   modport execute (output tid, r3, reg_we, mem_to_reg, alu_result, store_data, mem_we, stall);
   modport result  (input  tid, r3, reg_we, mem_to_reg, alu_result, store_data, mem_we, stall,
                    output rf_we, rf_tid, rf_r3, rf_data);
   modport decode  (input  rf_we, rf_tid, rf_r3, rf_data);
endinterface

// Host access windows and pipeline enable
interface host_if #(
   parameter int DMEM_AW = 8
);
   import barrel_pkg::*;

   logic               pipe_en;
   logic               imem_we;
   imem_addr_t         imem_addr;
   instr_t             imem_data;
   tid_t               reg_rd_tid;
   reg_idx_t           reg_rd_idx;
   word_t              reg_rd_data;
   logic [DMEM_AW-1:0] dmem_addr;
   logic               dmem_we;
   word_t              dmem_wdata;
   word_t              dmem_rdata;
   logic               wb_stall;

   modport host    (output pipe_en, imem_we, imem_addr, imem_data, reg_rd_tid, reg_rd_idx,
                           dmem_addr, dmem_we, dmem_wdata,
                    input  reg_rd_data, dmem_rdata, wb_stall);
   modport decode  (input  pipe_en, imem_we, imem_addr, imem_data, reg_rd_tid, reg_rd_idx,
                    output reg_rd_data);
   modport execute (input  pipe_en);
   modport result  (input  pipe_en, dmem_addr, dmem_we, dmem_wdata,
                    output dmem_rdata, wb_stall);
endinterface

/* source/barrel_pkg.sv */
package barrel_pkg;

   ////////////////////////////////////////
   // Widths
   typedef logic [31:0] word_t;
   typedef logic [31:0] instr_t;
   typedef logic [8:0]  pc_t;          // Per-thread PC
   typedef logic [1:0]  tid_t;
   typedef logic [10:0] imem_addr_t;   // {tid, pc}
   typedef logic [2:0]  reg_idx_t;
   typedef logic [3:0]  op_t;
   typedef logic [3:0]  cond_t;
   typedef logic [3:0]  flags_t;       // N Z C V, N in msb
   typedef logic [15:0] apb_addr_t;

   localparam int NUM_THREADS = 4;
   localparam int NUM_REGS    = 8;

   ////////////////////////////////////////
   // Instruction fields
   localparam int OP_LSB     = 0;
   localparam int COND_LSB   = 4;
   localparam int R1_LSB     = 10;
   localparam int R2_LSB     = 13;
   localparam int R3_LSB     = 16;
   localparam int OFFSET_LSB = 19;
   localparam int OFFSET_W   = 9;      // Sign extended where added
   localparam int STALL_BIT  = 30;

   // Opcodes, 12 to 15 behave as NOP
   localparam op_t OP_NOP    = 4'd0;
   localparam op_t OP_ADD    = 4'd1;
   localparam op_t OP_SUB    = 4'd2;
   localparam op_t OP_AND    = 4'd3;
   localparam op_t OP_OR     = 4'd4;
   localparam op_t OP_XOR    = 4'd5;
   localparam op_t OP_ADDI   = 4'd6;
   localparam op_t OP_LOAD   = 4'd7;
   localparam op_t OP_STORE  = 4'd8;
   localparam op_t OP_CMP    = 4'd9;
   localparam op_t OP_BRANCH = 4'd10;
   localparam op_t OP_JUMP   = 4'd11;

   // Pass conditions
   localparam cond_t COND_AL = 4'd0;
   localparam cond_t COND_EQ = 4'd1;
   localparam cond_t COND_NE = 4'd2;
   localparam cond_t COND_CS = 4'd3;
   localparam cond_t COND_CC = 4'd4;
   localparam cond_t COND_MI = 4'd5;
   localparam cond_t COND_PL = 4'd6;
   localparam cond_t COND_VS = 4'd7;
   localparam cond_t COND_VC = 4'd8;
   localparam cond_t COND_LT = 4'd9;
   localparam cond_t COND_GE = 4'd10;

   ////////////////////////////////////////
   // APB map
   localparam apb_addr_t CMD_ADDR    = 16'h0000;
   localparam apb_addr_t STATUS_ADDR = 16'h0004;
   localparam apb_addr_t REG_BASE    = 16'h0100;  // tid*32 + reg*4
   localparam apb_addr_t DMEM_BASE   = 16'h1000;  // word*4
   localparam apb_addr_t IMEM_BASE   = 16'h2000;  // {tid, pc}*4

   localparam int CMD_RUN_BIT  = 0;
   localparam int CMD_STEP_BIT = 1;

endpackage
